/* hw/bch_consts.svh */
`ifndef BCH_CONSTS_SVH
`define BCH_CONSTS_SVH

// code size, fixed at 15/5 with t = 3
`define BCH_N 15
`define BCH_K 5
`define BCH_T 3
`define BCH_M 4

// g(x) = x^10 + x^8 + x^5 + x^4 + x^2 + x + 1 (0x537)
// leading x^10 term is implicit in the LFSR feedback
`define BCH_GEN_POLY 10'h137

// register map
`define REG_CTRL    2'd0
`define REG_ENC_CNT 2'd1
`define REG_CHK_CNT 2'd2
`define REG_ERR_CNT 2'd3

// control register bit positions
`define CTRL_ENC_EN 0
`define CTRL_CHK_EN 1
`define CTRL_CLEAR  15

`endif

/* hw/bch_pkg.sv */
`include "bch_consts.svh"

package bch_pkg;

	// message bits in, systematic codeword out
	typedef logic [`BCH_K-1:0] msg_t;
	typedef logic [`BCH_N-1:0] code_t;

	// parity on the encode side, remainder on the check side
	typedef logic [`BCH_N-`BCH_K-1:0] parity_t;

	// frame position from the LFSR counter
	typedef logic [`BCH_M-1:0] frame_cnt_t;

	// register port
	typedef logic [1:0]  reg_addr_t;
	typedef logic [15:0] reg_data_t;

	typedef enum logic [1:0] {
		frame_idle,	// waiting for a message
		frame_run,	// encoder busy, collecting bits
		frame_hold	// codeword offered
	} frame_state_t;

	typedef enum logic [1:0] {
		rem_idle,	// waiting for a received word
		rem_shift,	// dividing
		rem_hold	// remainder offered
	} rem_state_t;

endpackage

/* hw/lfsr_counter.sv */
`timescale 1ns/1ps

`include "bch_consts.svh"

module lfsr_counter (
	input  logic                clk,
	input  logic                reset,
	input  logic                restart,
	output bch_pkg::frame_cnt_t count
);
	import bch_pkg::*;

	localparam frame_cnt_t seed = '1;

	frame_cnt_t state;

	// x^4 + x^3 + 1, walks all 15 non-zero states
	always_ff @(posedge clk) begin
		if (reset || restart) begin
			state <= seed;
		end else begin
			state <= {state[`BCH_M-2:0], state[`BCH_M-1] ^ state[`BCH_M-2]};
		end
	end

	assign count = state;

endmodule

/* hw/bch_encode.sv */
`timescale 1ns/1ps

`include "bch_consts.svh"

module bch_encode (
	input  logic clk,
	input  logic reset,
	input  logic start,
	input  logic data_in,
	output logic vdin,
	output logic data_out
);
	import bch_pkg::*;

	// counter value after a number of steps from the seed
	function automatic frame_cnt_t count_at(input int steps);
		frame_cnt_t c;
		c = '1;
		for (int i = 0; i < steps; i++) begin
			c = {c[`BCH_M-2:0], c[`BCH_M-1] ^ c[`BCH_M-2]};
		end
		return c;
	endfunction

	localparam frame_cnt_t last_msg_pos = count_at(`BCH_K - 1);
	localparam parity_t gen = `BCH_GEN_POLY;

	frame_cnt_t count;
	parity_t    lfsr;
	logic       vdin_r;
	logic       lfsr_in;

	lfsr_counter u_counter (
		.clk     (clk),
		.reset   (reset),
		.restart (start),
		.count   (count)
	);

	// message window opens on start, closes at the K-th position
	always_ff @(posedge clk) begin
		if (reset) begin
			vdin_r <= 1'b0;
		end else if (start) begin
			vdin_r <= 1'b1;
		end else if (count == last_msg_pos) begin
			vdin_r <= 1'b0;
		end
	end

	assign vdin = vdin_r;

	// feedback only while message bits come in
	assign lfsr_in = vdin_r & (lfsr[`BCH_N-`BCH_K-1] ^ data_in);

	always_ff @(posedge clk) begin
		if (reset || start) begin
			lfsr <= '0;
		end else begin
			lfsr <= {lfsr[`BCH_N-`BCH_K-2:0], 1'b0} ^ ({(`BCH_N-`BCH_K){lfsr_in}} & gen);
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			data_out <= 1'b0;
		end else begin
			data_out <= vdin_r ? data_in : lfsr[`BCH_N-`BCH_K-1];	// message, then parity
		end
	end

	a_vdin_window: assert property (@(posedge clk) disable iff (reset)
		start |=> vdin [*`BCH_K] ##1 !vdin);

endmodule

/* hw/bch_frame.sv */
`timescale 1ns/1ps

`include "bch_consts.svh"

module bch_frame (
	input  logic           clk,
	input  logic           reset,
	input  logic           enc_en,
	input  logic           msg_valid,
	output logic           msg_ready,
	input  bch_pkg::msg_t  msg_data,
	output logic           code_valid,
	input  logic           code_ready,
	output bch_pkg::code_t code_data,
	output logic           enc_done
);
	import bch_pkg::*;

	localparam logic [3:0] last_bit = 4'(`BCH_N - 1);

	frame_state_t state;
	msg_t         msg_sr;
	code_t        code_sr;
	logic         start;
	logic         vdin;
	logic         data_out;
	logic         capt;	// data_out carries codeword bits
	logic [3:0]   bit_cnt;

	bch_encode u_encode (
		.clk      (clk),
		.reset    (reset),
		.start    (start),
		.data_in  (msg_sr[`BCH_K-1]),
		.vdin     (vdin),
		.data_out (data_out)
	);

	assign msg_ready  = enc_en && (state == frame_idle);
	assign code_valid = (state == frame_hold);
	assign code_data  = code_sr;
	assign enc_done   = code_valid && code_ready;

	always_ff @(posedge clk) begin
		if (reset) begin
			state   <= frame_idle;
			start   <= 1'b0;
			capt    <= 1'b0;
			bit_cnt <= '0;
		end else begin
			start <= 1'b0;
			case (state)
				frame_idle: if (msg_valid && msg_ready) begin
					state <= frame_run;
					start <= 1'b1;
				end
				frame_run: if (capt) begin
					if (bit_cnt == last_bit) begin
						capt    <= 1'b0;
						bit_cnt <= '0;
						state   <= frame_hold;
					end else begin
						bit_cnt <= bit_cnt + 4'd1;
					end
				end else if (vdin) begin
					capt <= 1'b1;	// first bit shows one cycle after vdin
				end
				frame_hold: if (code_ready) state <= frame_idle;
				default: state <= frame_idle;
			endcase
		end
	end

	// message out MSB first, codeword in with first bit ending at MSB
	always_ff @(posedge clk) begin
		if (msg_valid && msg_ready) msg_sr <= msg_data;
		else if (vdin) msg_sr <= {msg_sr[`BCH_K-2:0], 1'b0};
		if (state == frame_run && capt) code_sr <= {code_sr[`BCH_N-2:0], data_out};
	end

	a_code_stable: assert property (@(posedge clk) disable iff (reset)
		code_valid && !code_ready |=> code_valid && $stable(code_data));

	// one frame in flight
	a_one_frame: assert property (@(posedge clk) disable iff (reset)
		msg_valid && msg_ready |=> !msg_ready until_with (code_valid && code_ready));

endmodule

/* hw/bch_remainder.sv */
`timescale 1ns/1ps

`include "bch_consts.svh"

module bch_remainder (
	input  logic             clk,
	input  logic             reset,
	input  logic             chk_en,
	input  logic             rx_valid,
	output logic             rx_ready,
	input  bch_pkg::code_t   rx_data,
	output logic             rem_valid,
	input  logic             rem_ready,
	output bch_pkg::parity_t rem_data,
	output logic             rem_err,
	output logic             chk_done,
	output logic             chk_err
);
	import bch_pkg::*;

	localparam parity_t gen = `BCH_GEN_POLY;
	localparam logic [3:0] n_bits = 4'(`BCH_N);

	rem_state_t state;
	code_t      word_sr;
	parity_t    rem;
	logic       err_r;
	logic [3:0] bit_cnt;

	assign rx_ready  = chk_en && (state == rem_idle);
	assign rem_valid = (state == rem_hold);
	assign rem_data  = rem;
	assign rem_err   = err_r;
	assign chk_done  = rem_valid && rem_ready;
	assign chk_err   = chk_done && err_r;	// flag travels with the transfer

	always_ff @(posedge clk) begin
		if (reset) begin
			state   <= rem_idle;
			bit_cnt <= '0;
			err_r   <= 1'b0;
		end else begin
			case (state)
				rem_idle: if (rx_valid && rx_ready) begin
					state   <= rem_shift;
					bit_cnt <= '0;
				end
				rem_shift: if (bit_cnt == n_bits) begin
					err_r <= |rem;	// extra cycle to register the flag
					state <= rem_hold;
				end else begin
					bit_cnt <= bit_cnt + 4'd1;
				end
				rem_hold: if (rem_ready) state <= rem_idle;
				default: state <= rem_idle;
			endcase
		end
	end

	// s <- s*x + b mod g, MSB of the word first
	always_ff @(posedge clk) begin
		if (rx_valid && rx_ready) begin
			word_sr <= rx_data;
			rem     <= '0;
		end else if (state == rem_shift && bit_cnt != n_bits) begin
			word_sr <= {word_sr[`BCH_N-2:0], 1'b0};
			rem     <= {rem[`BCH_N-`BCH_K-2:0], word_sr[`BCH_N-1]}
				^ ({(`BCH_N-`BCH_K){rem[`BCH_N-`BCH_K-1]}} & gen);
		end
	end

	// rise is seen one tick after the edge that sets rem_hold
	a_rem_after_rx: assert property (@(posedge clk) disable iff (reset)
		$rose(rem_valid) |-> $past(rx_valid && rx_ready, `BCH_N + 2));

endmodule

/* hw/bch_link_regs.sv */
`timescale 1ns/1ps

`include "bch_consts.svh"

module bch_link_regs (
	input  logic               clk,
	input  logic               reset,
	input  logic               reg_we,
	input  bch_pkg::reg_addr_t reg_addr,
	input  bch_pkg::reg_data_t reg_wdata,
	output bch_pkg::reg_data_t reg_rdata,
	output logic               enc_en,
	output logic               chk_en,
	input  logic               enc_done,
	input  logic               chk_done,
	input  logic               chk_err
);
	import bch_pkg::*;

	// stick at all-ones instead of wrapping
	function automatic reg_data_t sat_inc(input reg_data_t v, input logic hit);
		return (hit && v != '1) ? v + reg_data_t'(1) : v;
	endfunction

	reg_data_t enc_cnt;
	reg_data_t chk_cnt;
	reg_data_t err_cnt;
	logic      ctrl_wr;
	logic      clear;

	assign ctrl_wr = reg_we && (reg_addr == `REG_CTRL);
	assign clear   = ctrl_wr && reg_wdata[`CTRL_CLEAR];

	always_ff @(posedge clk) begin
		if (reset) begin
			enc_en  <= 1'b0;
			chk_en  <= 1'b0;
			enc_cnt <= '0;
			chk_cnt <= '0;
			err_cnt <= '0;
		end else begin
			if (ctrl_wr) begin
				enc_en <= reg_wdata[`CTRL_ENC_EN];
				chk_en <= reg_wdata[`CTRL_CHK_EN];
			end
			enc_cnt <= clear ? '0 : sat_inc(enc_cnt, enc_done);	// clear beats a pulse
			chk_cnt <= clear ? '0 : sat_inc(chk_cnt, chk_done);
			err_cnt <= clear ? '0 : sat_inc(err_cnt, chk_err);
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			reg_rdata <= '0;
		end else begin
			case (reg_addr)
				`REG_CTRL:    reg_rdata <= {14'd0, chk_en, enc_en};
				`REG_ENC_CNT: reg_rdata <= enc_cnt;
				`REG_CHK_CNT: reg_rdata <= chk_cnt;
				default:      reg_rdata <= err_cnt;
			endcase
		end
	end

endmodule

/* hw/bch_link_top.sv */
`timescale 1ns/1ps

module bch_link_top (
	input  logic               clk,
	input  logic               reset,
	input  logic               msg_valid,
	output logic               msg_ready,
	input  bch_pkg::msg_t      msg_data,
	output logic               code_valid,
	input  logic               code_ready,
	output bch_pkg::code_t     code_data,
	input  logic               rx_valid,
	output logic               rx_ready,
	input  bch_pkg::code_t     rx_data,
	output logic               rem_valid,
	input  logic               rem_ready,
	output bch_pkg::parity_t   rem_data,
	output logic               rem_err,
	input  logic               reg_we,
	input  bch_pkg::reg_addr_t reg_addr,
	input  bch_pkg::reg_data_t reg_wdata,
	output bch_pkg::reg_data_t reg_rdata
);

	logic enc_en;
	logic chk_en;
	logic enc_done;
	logic chk_done;
	logic chk_err;

	// encode path
	bch_frame u_frame (
		.clk(clk), .reset(reset), .enc_en(enc_en),
		.msg_valid(msg_valid), .msg_ready(msg_ready), .msg_data(msg_data),
		.code_valid(code_valid), .code_ready(code_ready), .code_data(code_data),
		.enc_done(enc_done)
	);

	// check path
	bch_remainder u_remainder (
		.clk(clk), .reset(reset), .chk_en(chk_en),
		.rx_valid(rx_valid), .rx_ready(rx_ready), .rx_data(rx_data),
		.rem_valid(rem_valid), .rem_ready(rem_ready), .rem_data(rem_data),
		.rem_err(rem_err), .chk_done(chk_done), .chk_err(chk_err)
	);

	bch_link_regs u_regs (
		.clk(clk), .reset(reset), .reg_we(reg_we), .reg_addr(reg_addr),
		.reg_wdata(reg_wdata), .reg_rdata(reg_rdata),
		.enc_en(enc_en), .chk_en(chk_en),
		.enc_done(enc_done), .chk_done(chk_done), .chk_err(chk_err)
	);

endmodule

/* verif/clk_gen.sv */
`timescale 1ns/1ps

module clk_gen (
	output logic clk,
	output logic reset
);

	localparam real half_period = 2.0;	// 4 ns clock
	localparam int reset_cycles = 8;

	initial begin
		clk = 1'b0;
		forever #(half_period) clk = ~clk;
	end

	initial begin
		reset = 1'b1;
		repeat (reset_cycles) @(posedge clk);
		reset <= 1'b0;
	end

endmodule

/* verif/bch_link_tb.sv */
`timescale 1ns/1ps

`include "bch_consts.svh"

module bch_link_tb;
	import bch_pkg::*;

	localparam int words = 64;
	localparam int timeout_cycles = words * (`BCH_N + 8) * 4 + 4000;

	logic clk, reset;
	logic msg_valid, msg_ready, code_valid, code_ready;
	logic rx_valid, rx_ready, rem_valid, rem_ready, rem_err, reg_we;
	msg_t msg_data;
	code_t code_data, rx_data;
	parity_t rem_data;
	reg_addr_t reg_addr;
	reg_data_t reg_wdata, reg_rdata;

	logic [31:0] lcg_state = 32'd32;
	int cycle_count = 0;
	int enc_seen = 0;	// codeword transfers
	int chk_seen = 0;	// remainder transfers
	int err_seen = 0;	// flagged remainders
	code_t codes[$];

	clk_gen u_clk_gen (.clk(clk), .reset(reset));

	bch_link_top u_dut (
		.clk(clk), .reset(reset),
		.msg_valid(msg_valid), .msg_ready(msg_ready), .msg_data(msg_data),
		.code_valid(code_valid), .code_ready(code_ready), .code_data(code_data),
		.rx_valid(rx_valid), .rx_ready(rx_ready), .rx_data(rx_data),
		.rem_valid(rem_valid), .rem_ready(rem_ready), .rem_data(rem_data),
		.rem_err(rem_err), .reg_we(reg_we), .reg_addr(reg_addr),
		.reg_wdata(reg_wdata), .reg_rdata(reg_rdata)
	);

	function automatic logic [31:0] next_rand();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state;
	endfunction

	// upper bits only, low LCG bits cycle fast
	function automatic int rand_range(input int n);
		return int'((next_rand() >> 16) % n);
	endfunction

	// long division by g(x) with its x^10 term
	function automatic parity_t poly_mod(input code_t word);
		code_t r;
		code_t g;
		r = word;
		g = code_t'({1'b1, `BCH_GEN_POLY});
		for (int i = `BCH_N - 1; i >= `BCH_N - `BCH_K; i--) begin
			if (r[i]) r = r ^ (g << (i - (`BCH_N - `BCH_K)));
		end
		return r[`BCH_N-`BCH_K-1:0];
	endfunction

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Checks failed");
		$fatal(1);
	endtask

	task automatic check_code(input string name, input code_t exp, input code_t act);
		if (exp !== act)
			abort_run($sformatf("[FAIL] %s expected %h actual %h", name, exp, act));
	endtask

	task automatic check_rem(input string name, input parity_t exp, input logic exp_err,
			input parity_t act, input logic act_err);
		if (exp !== act || exp_err !== act_err)
			abort_run($sformatf("[FAIL] %s expected rem %h err %b actual rem %h err %b",
				name, exp, exp_err, act, act_err));
	endtask

	task automatic check_reg(input string name, input reg_data_t exp, input reg_data_t act);
		if (exp !== act)
			abort_run($sformatf("[FAIL] %s expected %h actual %h", name, exp, act));
	endtask

	task automatic write_reg(input reg_addr_t a, input reg_data_t d);
		reg_we    <= 1'b1;
		reg_addr  <= a;
		reg_wdata <= d;
		@(posedge clk);
		reg_we <= 1'b0;
	endtask

	// rdata is registered, so sample on the second edge
	task automatic read_reg(input reg_addr_t a, output reg_data_t d);
		reg_addr <= a;
		@(posedge clk);
		@(posedge clk);
		d = reg_rdata;
	endtask

	task automatic send_msg(input msg_t m);
		repeat (rand_range(3)) @(posedge clk);
		msg_valid <= 1'b1;
		msg_data  <= m;
		do @(posedge clk); while (!msg_ready);
		msg_valid <= 1'b0;
	endtask

	task automatic take_code(output code_t c);
		logic done;
		done = 1'b0;
		while (!done) begin
			code_ready <= (rand_range(4) != 0);	// back-pressure about a quarter of cycles
			@(posedge clk);
			if (code_valid && code_ready) begin
				c = code_data;
				done = 1'b1;
			end
		end
		code_ready <= 1'b0;
		enc_seen++;
	endtask

	task automatic send_word(input code_t w);
		repeat (rand_range(3)) @(posedge clk);
		rx_valid <= 1'b1;
		rx_data  <= w;
		do @(posedge clk); while (!rx_ready);
		rx_valid <= 1'b0;
	endtask

	task automatic take_rem(output parity_t r, output logic e);
		logic done;
		done = 1'b0;
		while (!done) begin
			rem_ready <= (rand_range(4) != 0);
			@(posedge clk);
			if (rem_valid && rem_ready) begin
				r = rem_data;
				e = rem_err;
				done = 1'b1;
			end
		end
		rem_ready <= 1'b0;
		chk_seen++;
	endtask

	// both valids high while the paths are off, nothing may move
	task automatic hold_idle(input string name);
		msg_valid <= 1'b1;
		msg_data  <= msg_t'(rand_range(32));
		rx_valid  <= 1'b1;
		rx_data   <= code_t'(rand_range(1 << `BCH_N));
		repeat (50) begin
			@(posedge clk);
			if (msg_ready) abort_run({name, ": msg_ready went high on a disabled encode path"});
			if (rx_ready) abort_run({name, ": rx_ready went high on a disabled check path"});
			if (code_valid || rem_valid) abort_run({name, ": a result appeared while disabled"});
		end
		msg_valid <= 1'b0;
		rx_valid  <= 1'b0;
	endtask

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count > timeout_cycles)
			abort_run($sformatf("run did not finish within %0d cycles", timeout_cycles));
	end

	initial begin
		msg_t m;
		code_t c, w, mask;
		parity_t r, exp_r;
		logic e;
		reg_data_t d;
		int n, flips, pos;

		msg_valid = 1'b0;
		msg_data  = '0;
		code_ready = 1'b0;
		rx_valid  = 1'b0;
		rx_data   = '0;
		rem_ready = 1'b0;
		reg_we    = 1'b0;
		reg_addr  = '0;
		reg_wdata = '0;

		do @(posedge clk); while (reset);

		hold_idle("after reset");
		read_reg(`REG_ENC_CNT, d);
		check_reg("enc count after reset", '0, d);
		write_reg(`REG_CTRL, 16'h0003);

		// encode with back-pressure
		for (int i = 0; i < words; i++) begin
			m = msg_t'(rand_range(32));
			send_msg(m);
			take_code(c);
			check_code($sformatf("encode word %0d", i), {m, poly_mod({m, 10'd0})}, c);
			codes.push_back(c);
		end

		// clean codewords divide evenly
		for (int i = 0; i < words; i++) begin
			send_word(codes[i]);
			take_rem(r, e);
			check_rem($sformatf("clean word %0d", i), '0, 1'b0, r, e);
		end

		// 1 to 3 flips, distance 7 keeps the remainder non-zero
		for (int i = 0; i < words; i++) begin
			n = 1 + rand_range(`BCH_T);
			mask = '0;
			flips = 0;
			while (flips < n) begin
				pos = rand_range(`BCH_N);
				if (!mask[pos]) begin
					mask[pos] = 1'b1;
					flips++;
				end
			end
			w = codes[rand_range(words)] ^ mask;
			exp_r = poly_mod(w);
			send_word(w);
			take_rem(r, e);
			check_rem($sformatf("corrupt word %0d", i), exp_r, 1'b1, r, e);
			err_seen++;
		end

		read_reg(`REG_CTRL, d);
		check_reg("ctrl enabled", 16'h0003, d);
		read_reg(`REG_ENC_CNT, d);
		check_reg("enc count", reg_data_t'(enc_seen), d);
		read_reg(`REG_CHK_CNT, d);
		check_reg("chk count", reg_data_t'(chk_seen), d);
		read_reg(`REG_ERR_CNT, d);
		check_reg("err count", reg_data_t'(err_seen), d);

		write_reg(`REG_CTRL, 16'h0000);
		hold_idle("after disable");
		read_reg(`REG_CTRL, d);
		check_reg("ctrl disabled", 16'h0000, d);
		read_reg(`REG_ENC_CNT, d);
		check_reg("enc count held", reg_data_t'(enc_seen), d);

		write_reg(`REG_CTRL, 16'h8000);	// clear bit
		read_reg(`REG_ENC_CNT, d);
		check_reg("enc count cleared", '0, d);
		read_reg(`REG_CHK_CNT, d);
		check_reg("chk count cleared", '0, d);
		read_reg(`REG_ERR_CNT, d);
		check_reg("err count cleared", '0, d);

		$display("All checks passed");
		$finish;
	end

endmodule

/* compile.f */
+incdir+hw
hw/bch_pkg.sv
hw/lfsr_counter.sv
hw/bch_encode.sv
hw/bch_frame.sv
hw/bch_remainder.sv
hw/bch_link_regs.sv
hw/bch_link_top.sv
verif/clk_gen.sv
verif/bch_link_tb.sv

/* Bender.yml */
package:
  name: bch_link

export_include_dirs:
  - hw

sources:
  - target: rtl
    include_dirs:
      - hw
    files:
      - hw/bch_pkg.sv
      - hw/lfsr_counter.sv
      - hw/bch_encode.sv
      - hw/bch_frame.sv
      - hw/bch_remainder.sv
      - hw/bch_link_regs.sv
      - hw/bch_link_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - verif/clk_gen.sv
      - verif/bch_link_tb.sv
